/* compile.f */
+incdir+sim
logic/video_pkg.sv
logic/host_cmd_decoder.sv
logic/sync_polarity_fix.sv
logic/umuldiv.sv
logic/window_calc.sv
logic/video_window_top.sv
sim/tb_video_window.sv

/* logic/host_cmd_decoder.sv */
// Host command decoder
// First strobe of a transfer picks the command, later strobes
// carry its parameters into the timing and scale registers.
// Also keeps the wait-for-vsync flag

`default_nettype none

module host_cmd_decoder (
	input  wire logic                         clk_vid,
	input  wire logic                         i_rst,
	input  wire logic                         i_host_sel,
	input  wire logic                         i_host_strobe,
	input  wire logic [video_pkg::HOST_W-1:0] i_host_data,
	input  wire logic                         i_vs_norm,
	output video_pkg::video_timing_t          o_timing,
	output video_pkg::scale_cfg_t             o_scale,
	output logic                              o_vs_wait
);
	import video_pkg::*;

	logic       has_cmd;
	host_cmd_e  cmd;
	// Saturates at 8 so trailing timing words are dropped
	logic [3:0] param_cnt;
	logic       vs_d;
	logic       vs_rise;

	assign vs_rise = i_vs_norm & ~vs_d;

	always_ff @(posedge clk_vid) begin
		if (i_rst) begin
			has_cmd   <= 1'b0;
			cmd       <= CMD_NONE;
			param_cnt <= '0;
			o_timing  <= TIMING_1080P60;
			o_scale   <= '0;
			o_vs_wait <= 1'b0;
			vs_d      <= 1'b0;
		end else begin
			vs_d <= i_vs_norm;

			// Vsync edge clears the flag, a new wait command below wins
			if (vs_rise)
				o_vs_wait <= 1'b0;

			if (!i_host_sel) begin
				has_cmd <= 1'b0;
				cmd     <= CMD_NONE;
			end else if (i_host_strobe) begin
				if (!has_cmd) begin
					// Command word
					has_cmd   <= 1'b1;
					cmd       <= host_cmd_e'(i_host_data[7:0]);
					param_cnt <= '0;
					if (i_host_data[7:0] == CMD_VS_WAIT)
						o_vs_wait <= 1'b1;
				end else begin
					// Parameter word
					if (param_cnt != 4'd8)
						param_cnt <= param_cnt + 4'd1;

					case (cmd)
						CMD_VIDEO_TIMING: begin
							if (param_cnt < 4'd8) begin
								case (param_cnt[2:0])
									3'd0: o_timing.width  <= i_host_data[COORD_W-1:0];
									3'd1: o_timing.hfp    <= i_host_data[COORD_W-1:0];
									3'd2: o_timing.hs     <= i_host_data[COORD_W-1:0];
									3'd3: o_timing.hbp    <= i_host_data[COORD_W-1:0];
									3'd4: o_timing.height <= i_host_data[COORD_W-1:0];
									3'd5: o_timing.vfp    <= i_host_data[COORD_W-1:0];
									3'd6: o_timing.vs     <= i_host_data[COORD_W-1:0];
									default: o_timing.vbp <= i_host_data[COORD_W-1:0];
								endcase
							end
						end
						CMD_VSET: begin
							if (param_cnt == 4'd0)
								o_scale.vset <= i_host_data[COORD_W-1:0];
						end
						CMD_HSET: begin
							// Free-scale flag rides in the top bit
							if (param_cnt == 4'd0) begin
								o_scale.hset      <= i_host_data[COORD_W-1:0];
								o_scale.freescale <= i_host_data[HOST_W-1];
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/sync_polarity_fix.sv */
// Sync polarity fixer
// Measures the high and low run lengths of a sync and inverts it
// when the high run is the longer one, so the output is active high

`default_nettype none

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  wire logic clk_vid,
	input  wire logic i_rst,
	input  wire logic i_sync,
	output logic      o_sync
);

	logic             s1;
	logic             s2;
	logic [CNT_W-1:0] run_cnt;
	logic [CNT_W-1:0] low_len;
	logic [CNT_W-1:0] high_len;
	logic             pol;

	// No added delay on the sync itself
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_vid) begin
		if (i_rst) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			run_cnt  <= '0;
			low_len  <= '0;
			high_len <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Cycles since last transition, held at max on a dead sync
			if (s1 != s2)
				run_cnt <= '0;
			else if (run_cnt != '1)
				run_cnt <= run_cnt + CNT_W'(1);

			if (s1 & ~s2)
				low_len <= run_cnt;
			if (~s1 & s2)
				high_len <= run_cnt;

			pol <= (high_len > low_len);
		end
	end

endmodule

`default_nettype wire

/* logic/umuldiv.sv */
// Unsigned multiply-then-divide
// Product in one cycle, then a restoring division producing one
// quotient bit per cycle. Result saturates on overflow or zero divisor

`default_nettype none

module umuldiv #(
	parameter int MUL_W = 24,
	parameter int DIV_W = 12
) (
	input  wire logic             clk_vid,
	input  wire logic             i_rst,
	input  wire logic             i_start,
	input  wire logic [MUL_W-1:0] i_mul_a,
	input  wire logic [MUL_W-1:0] i_mul_b,
	input  wire logic [DIV_W-1:0] i_div,
	output logic                  o_busy,
	output logic [MUL_W-1:0]      o_result
);

	localparam int CMP_W  = (MUL_W > DIV_W) ? MUL_W : DIV_W;
	localparam int STEP_W = $clog2(MUL_W + 1);

	logic [MUL_W-1:0]   op_a;
	logic [MUL_W-1:0]   op_b;
	logic [DIV_W-1:0]   op_d;
	logic [2*MUL_W-1:0] product;
	logic               mul_phase;
	logic [STEP_W-1:0]  step;
	logic [DIV_W-1:0]   rem;
	logic [DIV_W:0]     trial;
	logic [DIV_W:0]     diff;
	logic [MUL_W-1:0]   dividend_lo;
	logic [MUL_W-1:0]   quo;
	logic               sat;

	assign product  = {{MUL_W{1'b0}}, op_a} * {{MUL_W{1'b0}}, op_b};
	assign trial    = {rem, dividend_lo[MUL_W-1]};
	assign diff     = trial - {1'b0, op_d};
	assign o_result = sat ? '1 : quo;

	////////////////////////////////////////////////////////////
	// Control
	always_ff @(posedge clk_vid) begin
		if (i_rst) begin
			o_busy    <= 1'b0;
			mul_phase <= 1'b0;
			step      <= '0;
		end else if (i_start) begin
			o_busy    <= 1'b1;
			mul_phase <= 1'b1;
		end else if (mul_phase) begin
			mul_phase <= 1'b0;
			step      <= '0;
		end else if (o_busy) begin
			step <= step + STEP_W'(1);
			if (step == STEP_W'(MUL_W - 1))
				o_busy <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Datapath
	always_ff @(posedge clk_vid) begin
		if (i_start) begin
			op_a <= i_mul_a;
			op_b <= i_mul_b;
			op_d <= i_div;
		end

		if (mul_phase) begin
			// Upper half seeds the remainder, must stay below the divisor
			rem         <= DIV_W'(product[2*MUL_W-1 -: MUL_W]);
			dividend_lo <= product[MUL_W-1:0];
			quo         <= '0;
			sat         <= CMP_W'(product[2*MUL_W-1 -: MUL_W]) >= CMP_W'(op_d);
		end else if (o_busy) begin
			dividend_lo <= {dividend_lo[MUL_W-2:0], 1'b0};
			if (trial >= {1'b0, op_d}) begin
				rem <= diff[DIV_W-1:0];
				quo <= {quo[MUL_W-2:0], 1'b1};
			end else begin
				rem <= trial[DIV_W-1:0];
				quo <= {quo[MUL_W-2:0], 1'b0};
			end
		end
	end

endmodule

`default_nettype wire

/* logic/video_pkg.sv */
// Video window package
// Shared widths, host command codes and the structs that carry
// timing, scale settings, aspect ratio and the display window

`default_nettype none

package video_pkg;

	// Pixel and line coordinates
	localparam int COORD_W = 12;
	// Aspect component, top bit flags an absolute size
	localparam int AR_W    = 13;
	localparam int HOST_W  = 16;

	////////////////////////////////////////////////////////////
	// Host command codes
	typedef enum logic [7:0] {
		CMD_NONE         = 8'h00,
		CMD_VIDEO_TIMING = 8'h20,
		CMD_VSET         = 8'h27,
		CMD_VS_WAIT      = 8'h30,
		CMD_HSET         = 8'h37
	} host_cmd_e;

	////////////////////////////////////////////////////////////
	// Output timing, eight values in host load order
	typedef struct packed {
		logic [COORD_W-1:0] width;
		logic [COORD_W-1:0] hfp;
		logic [COORD_W-1:0] hs;
		logic [COORD_W-1:0] hbp;
		logic [COORD_W-1:0] height;
		logic [COORD_W-1:0] vfp;
		logic [COORD_W-1:0] vs;
		logic [COORD_W-1:0] vbp;
	} video_timing_t;

	typedef struct packed {
		logic [COORD_W-1:0] vset;
		logic [COORD_W-1:0] hset;
		logic               freescale;
	} scale_cfg_t;

	typedef struct packed {
		logic [AR_W-1:0] arx;
		logic [AR_W-1:0] ary;
	} aspect_t;

	typedef struct packed {
		logic [COORD_W-1:0] hmin;
		logic [COORD_W-1:0] hmax;
		logic [COORD_W-1:0] vmin;
		logic [COORD_W-1:0] vmax;
	} window_t;

	// Window calculator sequence
	typedef enum logic [2:0] {
		IDLE_CHECK,
		START_W,
		WAIT_W,
		START_H,
		WAIT_H,
		CLIP,
		CENTRE
	} window_state_e;

	// CEA 1080p60, loaded at reset
	localparam video_timing_t TIMING_1080P60 = '{
		width:  12'd1920, hfp: 12'd88, hs: 12'd44, hbp: 12'd148,
		height: 12'd1080, vfp: 12'd4,  vs: 12'd5,  vbp: 12'd36
	};

endpackage

`default_nettype wire

/* logic/video_window_top.sv */
// Video window and sync top level
// Host decoder, window calculator and the two sync polarity fixers

`default_nettype none

module video_window_top #(
	parameter int MUL_W = 24,
	parameter int CNT_W = 16
) (
	input  wire logic                         clk_vid,
	input  wire logic                         i_rst,
	input  wire logic                         i_host_sel,
	input  wire logic                         i_host_strobe,
	input  wire logic [video_pkg::HOST_W-1:0] i_host_data,
	input  wire video_pkg::aspect_t           i_aspect,
	input  wire logic                         i_hs,
	input  wire logic                         i_vs,
	output video_pkg::window_t                o_window,
	output logic                              o_vs_wait,
	output logic                              o_hs,
	output logic                              o_vs
);
	import video_pkg::*;

	video_timing_t timing;
	scale_cfg_t    scale;

	host_cmd_decoder u_decoder (
		.clk_vid       (clk_vid),
		.i_rst         (i_rst),
		.i_host_sel    (i_host_sel),
		.i_host_strobe (i_host_strobe),
		.i_host_data   (i_host_data),
		.i_vs_norm     (o_vs),
		.o_timing      (timing),
		.o_scale       (scale),
		.o_vs_wait     (o_vs_wait)
	);

	window_calc #(
		.MUL_W(MUL_W)
	) u_window (
		.clk_vid  (clk_vid),
		.i_rst    (i_rst),
		.i_timing (timing),
		.i_scale  (scale),
		.i_aspect (i_aspect),
		.o_window (o_window)
	);

	// Core syncs may come either polarity
	sync_polarity_fix #(.CNT_W(CNT_W)) sync_fix_h (
		.clk_vid (clk_vid),
		.i_rst   (i_rst),
		.i_sync  (i_hs),
		.o_sync  (o_hs)
	);

	sync_polarity_fix #(.CNT_W(CNT_W)) sync_fix_v (
		.clk_vid (clk_vid),
		.i_rst   (i_rst),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

endmodule

`default_nettype wire

/* logic/window_calc.sv */
// Display window calculator
// Loops over the output size, overrides and aspect ratio and
// produces the centred window, using one shared multiply-divide

`default_nettype none

module window_calc #(
	parameter int MUL_W = 24
) (
	input  wire logic                     clk_vid,
	input  wire logic                     i_rst,
	input  wire video_pkg::video_timing_t i_timing,
	input  wire video_pkg::scale_cfg_t    i_scale,
	input  wire video_pkg::aspect_t       i_aspect,
	output video_pkg::window_t            o_window
);
	import video_pkg::*;

	logic [COORD_W-1:0] hdmi_w;
	logic [COORD_W-1:0] hdmi_h;
	logic [COORD_W-1:0] ar_x;
	logic [COORD_W-1:0] ar_y;
	logic               ar_abs;
	window_state_e      state;
	logic [MUL_W-1:0]   wcalc;
	logic [MUL_W-1:0]   hcalc;
	logic [COORD_W-1:0] video_w;
	logic [COORD_W-1:0] video_h;
	logic [COORD_W-1:0] h_off;
	logic [COORD_W-1:0] v_off;
	logic               md_start;
	logic               md_busy;
	logic               md_done;
	logic [MUL_W-1:0]   md_mul_a;
	logic [MUL_W-1:0]   md_mul_b;
	logic [COORD_W-1:0] md_div;
	logic [MUL_W-1:0]   md_result;
	logic               size_direct;

	umuldiv #(
		.MUL_W(MUL_W),
		.DIV_W(COORD_W)
	) u_muldiv (
		.clk_vid  (clk_vid),
		.i_rst    (i_rst),
		.i_start  (md_start),
		.i_mul_a  (md_mul_a),
		.i_mul_b  (md_mul_b),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

	// Start pulse still in flight counts as busy
	assign md_done     = ~md_start & ~md_busy;
	assign size_direct = i_scale.freescale || (ar_x == '0) || (ar_y == '0) || ar_abs;
	assign h_off       = (i_timing.width - video_w) >> 1;
	assign v_off       = (i_timing.height - video_h) >> 1;

	// Output size and aspect, refreshed every cycle
	always_ff @(posedge clk_vid) begin
		hdmi_h <= (i_scale.vset != '0 && i_scale.vset < i_timing.height) ?
			i_scale.vset : i_timing.height;
		hdmi_w <= (i_scale.hset != '0 && i_scale.hset < i_timing.width) ?
			i_scale.hset : i_timing.width;
		ar_x   <= i_aspect.arx[COORD_W-1:0];
		ar_y   <= i_aspect.ary[COORD_W-1:0];
		ar_abs <= i_aspect.arx[AR_W-1] | i_aspect.ary[AR_W-1];
	end

	////////////////////////////////////////////////////////////
	// Sequencer
	always_ff @(posedge clk_vid) begin
		if (i_rst) begin
			state    <= IDLE_CHECK;
			md_start <= 1'b0;
			o_window <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				IDLE_CHECK: state <= size_direct ? CLIP : START_W;
				START_W: begin
					md_start <= 1'b1;
					state    <= WAIT_W;
				end
				WAIT_W:     if (md_done) state <= START_H;
				START_H: begin
					md_start <= 1'b1;
					state    <= WAIT_H;
				end
				WAIT_H:     if (md_done) state <= CLIP;
				CLIP:       state <= CENTRE;
				CENTRE: begin
					o_window.hmin <= h_off;
					o_window.hmax <= h_off + video_w - COORD_W'(1);
					o_window.vmin <= v_off;
					o_window.vmax <= v_off + video_h - COORD_W'(1);
					state         <= IDLE_CHECK;
				end
				default:    state <= IDLE_CHECK;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Video size datapath
	always_ff @(posedge clk_vid) begin
		case (state)
			IDLE_CHECK: begin
				// Full output or absolute size, no divide needed
				if (i_scale.freescale || ar_x == '0 || ar_y == '0) begin
					wcalc <= MUL_W'(hdmi_w);
					hcalc <= MUL_W'(hdmi_h);
				end else if (ar_abs) begin
					wcalc <= MUL_W'(ar_x);
					hcalc <= MUL_W'(ar_y);
				end
			end
			START_W: begin
				md_mul_a <= MUL_W'(hdmi_h);
				md_mul_b <= MUL_W'(ar_x);
				md_div   <= ar_y;
			end
			WAIT_W:     if (md_done) wcalc <= md_result;
			START_H: begin
				md_mul_a <= MUL_W'(hdmi_w);
				md_mul_b <= MUL_W'(ar_y);
				md_div   <= ar_x;
			end
			WAIT_H:     if (md_done) hcalc <= md_result;
			CLIP: begin
				video_w <= (wcalc > MUL_W'(hdmi_w)) ? hdmi_w : wcalc[COORD_W-1:0];
				video_h <= (hcalc > MUL_W'(hdmi_h)) ? hdmi_h : hcalc[COORD_W-1:0];
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the video window testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_video_window -Mdir obj_dir \
	&& ./obj_dir/Vtb_video_window | tee /dev/stderr | grep "TESTS PASSED" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* sim/tb_cases.svh */
// Window test cases
// Host settings, aspect ratio and the window that each one gives.
// Windows are centred on the output timing, sizes clipped to it

`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef struct packed {
	logic          load;
	video_timing_t timing;
	scale_cfg_t    scale;
	aspect_t       aspect;
	window_t       exp_win;
} tb_case_t;

localparam int NUM_CASES = 9;

// CEA 720p60
localparam video_timing_t TIMING_720P = '{
	12'd1280, 12'd110, 12'd40, 12'd220, 12'd720, 12'd5, 12'd5, 12'd20
};

tb_case_t cases [NUM_CASES] = '{
	// Aspect 0:0, full screen
	'{1'b0, TIMING_1080P60, '{12'd0, 12'd0, 1'b0}, '{13'd0, 13'd0},
		'{12'd0, 12'd1919, 12'd0, 12'd1079}},
	// 4:3 pillarbox, 1440 wide
	'{1'b0, TIMING_1080P60, '{12'd0, 12'd0, 1'b0}, '{13'd4, 13'd3},
		'{12'd240, 12'd1679, 12'd0, 12'd1079}},
	'{1'b0, TIMING_1080P60, '{12'd0, 12'd0, 1'b0}, '{13'd16, 13'd9},
		'{12'd0, 12'd1919, 12'd0, 12'd1079}},
	// Absolute 640x480
	'{1'b0, TIMING_1080P60, '{12'd0, 12'd0, 1'b0}, '{13'h1280, 13'h11E0},
		'{12'd640, 12'd1279, 12'd300, 12'd779}},
	// Height override 720, 4:3 gives 960 wide
	'{1'b0, TIMING_1080P60, '{12'd720, 12'd0, 1'b0}, '{13'd4, 13'd3},
		'{12'd480, 12'd1439, 12'd180, 12'd899}},
	// Free scale ignores the aspect
	'{1'b0, TIMING_1080P60, '{12'd0, 12'd1280, 1'b1}, '{13'd4, 13'd3},
		'{12'd320, 12'd1599, 12'd0, 12'd1079}},
	// New timing, preceded by an aborted load
	'{1'b1, TIMING_720P, '{12'd0, 12'd0, 1'b0}, '{13'd4, 13'd3},
		'{12'd160, 12'd1119, 12'd0, 12'd719}},
	// Back to 1080p, both overrides, 1600x900
	'{1'b1, TIMING_1080P60, '{12'd900, 12'd1600, 1'b0}, '{13'd0, 13'd0},
		'{12'd160, 12'd1759, 12'd90, 12'd989}},
	// Absolute 2000x1200 clipped to the screen
	'{1'b0, TIMING_1080P60, '{12'd0, 12'd0, 1'b0}, '{13'h17D0, 13'h14B0},
		'{12'd0, 12'd1919, 12'd0, 12'd1079}}
};

`endif

/* sim/tb_video_window.sv */
// Testbench for the video window top level
// Applies a table of host settings and aspect ratios and checks the
// window, then the vsync wait flag and both sync polarity fixers

`default_nettype none

module tb_video_window;
	timeunit 1ns;
	timeprecision 100ps;
	import video_pkg::*;

	`include "tb_cases.svh"

	localparam int LINE_CYC    = 50;
	localparam int HS_CYC      = 5;
	localparam int VS_LINES    = 2;
	localparam int FRAME_LINES = 8;
	localparam int FRAME_CYC   = LINE_CYC * FRAME_LINES;
	localparam int SETTLE_CYC  = 140;
	localparam int WDOG_CYC    = NUM_CASES * 200 + 4000;

	logic                clk_vid;
	logic                i_rst;
	logic                i_host_sel;
	logic                i_host_strobe;
	logic [HOST_W-1:0]   i_host_data;
	aspect_t             i_aspect;
	logic                i_hs;
	logic                i_vs;
	window_t             o_window;
	logic                o_vs_wait;
	logic                o_hs;
	logic                o_vs;

	integer              seed = 9;
	int                  errors = 0;
	int                  checks = 0;
	logic [HOST_W-1:0]   param_buf [8];
	// Sync generator state that the checks sample at falling edges
	int                  h_pos = 0;
	int                  line_pos = 0;
	logic                sync_low = 1'b0;

	video_window_top #(.MUL_W(24), .CNT_W(16)) uut (
		.clk_vid       (clk_vid),
		.i_rst         (i_rst),
		.i_host_sel    (i_host_sel),
		.i_host_strobe (i_host_strobe),
		.i_host_data   (i_host_data),
		.i_aspect      (i_aspect),
		.i_hs          (i_hs),
		.i_vs          (i_vs),
		.o_window      (o_window),
		.o_vs_wait     (o_vs_wait),
		.o_hs          (o_hs),
		.o_vs          (o_vs)
	);

	initial begin
		clk_vid = 1'b0;
		forever #20 clk_vid = ~clk_vid;
	end

	// Lines of 50 cycles with vsync counted in lines
	initial begin
		forever begin
			@(posedge clk_vid);
			#2;
			if (h_pos == LINE_CYC - 1) begin
				h_pos    = 0;
				line_pos = (line_pos == FRAME_LINES - 1) ? 0 : line_pos + 1;
			end else begin
				h_pos = h_pos + 1;
			end
			i_hs = (h_pos < HS_CYC) ^ sync_low;
			i_vs = (line_pos < VS_LINES) ^ sync_low;
		end
	end

	initial begin
		repeat (WDOG_CYC) @(posedge clk_vid);
		$display("Timeout, run still going after %0d cycles", WDOG_CYC);
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Host transfers

	task automatic next_cycle();
		@(posedge clk_vid);
		#2;
	endtask

	task automatic send_word(input logic [HOST_W-1:0] word);
		int gap;
		gap = $random(seed) & 3;
		repeat (gap) next_cycle();
		i_host_data   = word;
		i_host_strobe = 1'b1;
		next_cycle();
		i_host_strobe = 1'b0;
	endtask

	// Command word, then nparams words from param_buf, then deselect
	task automatic host_transfer(input logic [7:0] code, input int nparams);
		next_cycle();
		i_host_sel = 1'b1;
		send_word({8'h00, code});
		for (int k = 0; k < nparams; k++)
			send_word(param_buf[k]);
		next_cycle();
		i_host_sel = 1'b0;
		next_cycle();
	endtask

	task automatic apply_case(input tb_case_t c);
		if (c.load) begin
			// Half a load of junk values that the deselect drops
			param_buf[0] = 16'd1024;
			param_buf[1] = 16'd24;
			param_buf[2] = 16'd136;
			param_buf[3] = 16'd160;
			host_transfer(CMD_VIDEO_TIMING, 4);
			for (int k = 0; k < 8; k++)
				param_buf[k] = {4'h0, c.timing[COORD_W*(7-k) +: COORD_W]};
			host_transfer(CMD_VIDEO_TIMING, 8);
		end
		param_buf[0] = {4'h0, c.scale.vset};
		host_transfer(CMD_VSET, 1);
		param_buf[0] = {c.scale.freescale, 3'b000, c.scale.hset};
		host_transfer(CMD_HSET, 1);
		i_aspect = c.aspect;
	endtask

	////////////////////////////////////////////////////////////
	// Checks

	task automatic check_coord(input string name, input logic [COORD_W-1:0] got,
			input logic [COORD_W-1:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got == exp) else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	// Mid hsync pulse on the second vsync line
	task automatic check_syncs(input string tag);
		int n;
		n = 0;
		@(negedge clk_vid);
		while (!(h_pos == 2 && line_pos == 1) && n < 2 * FRAME_CYC) begin
			@(negedge clk_vid);
			n++;
		end
		checks++;
		assert (n < 2 * FRAME_CYC) else
			report_failure({"No mid-pulse sample found for the ", tag, " sync check"});
		if (n < 2 * FRAME_CYC) begin
			check_bit({"o_hs ", tag}, o_hs, sync_low ? ~i_hs : i_hs);
			check_bit({"o_vs ", tag}, o_vs, sync_low ? ~i_vs : i_vs);
		end
	endtask

	task automatic check_vs_wait();
		int  n;
		logic prev;
		n    = 0;
		prev = 1'b0;
		// Start of a vsync gap
		@(negedge clk_vid);
		while (!(prev && !o_vs) && n < 2 * FRAME_CYC) begin
			prev = o_vs;
			@(negedge clk_vid);
			n++;
		end
		check_bit("o_vs_wait idle", o_vs_wait, 1'b0);
		host_transfer(CMD_VS_WAIT, 0);
		@(negedge clk_vid);
		check_bit("o_vs_wait armed", o_vs_wait, 1'b1);
		n = 0;
		while (!o_vs && n < FRAME_CYC) begin
			check_bit("o_vs_wait in gap", o_vs_wait, 1'b1);
			@(negedge clk_vid);
			n++;
		end
		checks++;
		assert (o_vs) else
			report_failure("Vertical sync never rose while the wait flag was armed");
		n = 0;
		while (o_vs_wait && n < 10) begin
			@(negedge clk_vid);
			n++;
		end
		checks++;
		assert (n <= 5) else begin
			$display("Wait flag still high %0d cycles after the vsync edge", n);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		i_rst         = 1'b1;
		i_host_sel    = 1'b0;
		i_host_strobe = 1'b0;
		i_host_data   = '0;
		i_aspect      = '0;
		i_hs          = 1'b0;
		i_vs          = 1'b0;
		repeat (2) @(posedge clk_vid);
		#2;
		i_rst = 1'b0;

		for (int n = 0; n < NUM_CASES; n++) begin
			apply_case(cases[n]);
			repeat (SETTLE_CYC) @(posedge clk_vid);
			@(negedge clk_vid);
			check_coord($sformatf("o_window.hmin case %0d", n), o_window.hmin,
				cases[n].exp_win.hmin);
			check_coord($sformatf("o_window.hmax case %0d", n), o_window.hmax,
				cases[n].exp_win.hmax);
			check_coord($sformatf("o_window.vmin case %0d", n), o_window.vmin,
				cases[n].exp_win.vmin);
			check_coord($sformatf("o_window.vmax case %0d", n), o_window.vmax,
				cases[n].exp_win.vmax);
		end

		check_vs_wait();
		check_syncs("active high");

		// Flip the core syncs and give the fixers three frames
		@(negedge clk_vid);
		sync_low = 1'b1;
		repeat (3 * FRAME_CYC) @(posedge clk_vid);
		check_syncs("active low");

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
